// File: verilog/lab_pkg.sv
package lab_pkg;

    ////////////////////////////////////////
    // board widths
    ////////////////////////////////////////

    localparam w_key   = 4;                     // last key is the reset.
    localparam w_sw    = 2;
    localparam w_led   = 4;
    localparam w_count = 8;

    ////////////////////////////////////////
    // value types
    ////////////////////////////////////////

    typedef logic [w_count - 1:0] count_t;      // counter value, one byte.
    typedef logic [w_sw    - 1:0] step_shift_t; // log2 of the step size.

    // one-cycle key events, one per lab key
    typedef struct packed
    {
        logic toggle_dir;                       // key 0.
        logic toggle_run;                       // key 1.
        logic clear;                            // key 2.
    } key_evt_t;

    typedef struct packed
    {
        logic        run;
        logic        down;
        step_shift_t step_shift;
    } lab_ctrl_t;

endpackage

// File: verilog/slow_clk_gen.sv
`timescale 1ns/1ns

module slow_clk_gen
# (
    parameter period_cycles = 1000
)
(
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam w_cnt = $clog2 (period_cycles + 1);

    logic [w_cnt - 1:0] cnt;

    // down-counter, the strobe fires as it wraps.
    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            cnt  <= w_cnt' (period_cycles - 1);
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= w_cnt' (period_cycles - 1);  // reload for next period.
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

// File: verilog/key_sync.sv
`timescale 1ns/1ns

module key_sync
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [2:0]                 key,
    input  logic [lab_pkg::w_sw - 1:0] sw,
    output lab_pkg::key_evt_t          key_evt,
    output lab_pkg::step_shift_t       sw_sync
);

    logic [2:0]                 key_s1;
    logic [2:0]                 key_s2;
    logic [2:0]                 key_prev;
    logic [2:0]                 key_rise;
    logic [lab_pkg::w_sw - 1:0] sw_s1;

    assign key_rise = key_s2 & ~key_prev;       // rising edge after sync.

    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            key_s1   <= '0;
            key_s2   <= '0;
            key_prev <= '0;
            key_evt  <= '0;
        end
        else
        begin
            key_s1   <= key;
            key_s2   <= key_s1;
            key_prev <= key_s2;
            key_evt  <= '{toggle_dir: key_rise [0],
                          toggle_run: key_rise [1],
                          clear:      key_rise [2]};
        end
    end

    // switches are levels, two flops are enough.
    always_ff @ (posedge clk)
    begin
        sw_s1   <= sw;
        sw_sync <= sw_s1;
    end

endmodule

// File: verilog/lab_ctrl_regs.sv
`timescale 1ns/1ns

module lab_ctrl_regs
(
    input  logic                 clk,
    input  logic                 rst,
    input  lab_pkg::key_evt_t    key_evt,
    input  lab_pkg::step_shift_t sw_sync,
    output lab_pkg::lab_ctrl_t   ctrl
);

    ////////////////////////////////////////
    // step size follows the switches
    ////////////////////////////////////////

    always_ff @ (posedge clk)
    begin
        ctrl.step_shift <= sw_sync;             // reloaded every cycle.
    end

    ////////////////////////////////////////
    // run and direction toggles
    ////////////////////////////////////////

    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            ctrl.run  <= 1'b1;                  // start running.
            ctrl.down <= 1'b0;                  // count up.
        end
        else
        begin
            if (key_evt.toggle_run)
                ctrl.run <= ~ctrl.run;

            if (key_evt.toggle_dir)
                ctrl.down <= ~ctrl.down;
        end
    end

endmodule

// File: verilog/lab_counter.sv
`timescale 1ns/1ns

module lab_counter
(
    input  logic               clk,
    input  logic               rst,
    input  logic               tick,
    input  logic               clear,
    input  lab_pkg::lab_ctrl_t ctrl,
    output lab_pkg::count_t    count,
    output logic               count_new
);

    lab_pkg::count_t step;

    assign step = lab_pkg::count_t' (1) << ctrl.step_shift;  // 1, 2, 4 or 8.

    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            count     <= '0;
            count_new <= 1'b0;
        end
        else if (clear)
        begin
            count     <= '0;                    // clear wins over a tick.
            count_new <= 1'b0;
        end
        else if (tick & ctrl.run)
        begin
            // wraps modulo 256 in both directions.
            count     <= ctrl.down ? count - step : count + step;
            count_new <= 1'b1;
        end
        else
        begin
            count_new <= 1'b0;
        end
    end

endmodule

// File: verilog/uart_byte_tx.sv
`timescale 1ns/1ns

module uart_byte_tx
# (
    parameter bit_cycles = 217
)
(
    input  logic            clk,
    input  logic            rst,
    input  lab_pkg::count_t data,
    input  logic            load,
    output logic            tx
);

    localparam w_baud = $clog2 (bit_cycles + 1);

    typedef enum logic [1:0]
    {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t              state;
    logic [w_baud - 1:0] baud_cnt;
    logic [2:0]          bit_idx;
    lab_pkg::count_t     shreg;

    wire bit_done = (baud_cnt == '0);           // end of the current bit.

    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            state    <= st_idle;
            tx       <= 1'b1;                   // line idles high.
            baud_cnt <= '0;
            bit_idx  <= '0;
        end
        else
        begin
            if (state != st_idle)
                baud_cnt <= bit_done ? w_baud' (bit_cycles - 1) : baud_cnt - 1'b1;

            case (state)
            st_idle:
                if (load)                       // a busy load is simply lost.
                begin
                    state    <= st_start;
                    tx       <= 1'b0;
                    baud_cnt <= w_baud' (bit_cycles - 1);
                end
            st_start:
                if (bit_done)
                begin
                    state   <= st_data;
                    tx      <= shreg [0];       // lsb first.
                    bit_idx <= '0;
                end
            st_data:
                if (bit_done)
                begin
                    if (bit_idx == 3'd7)
                    begin
                        state <= st_stop;
                        tx    <= 1'b1;
                    end
                    else
                    begin
                        tx      <= shreg [0];
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
            st_stop:
                if (bit_done)
                    state <= st_idle;
            default:
                state <= st_idle;
            endcase
        end
    end

    // payload shifts out one bit per data slot.
    always_ff @ (posedge clk)
    begin
        if (state == st_idle && load)
            shreg <= data;
        else if ((state == st_start || state == st_data) && bit_done)
            shreg <= shreg >> 1;
    end

endmodule

// File: verilog/lab_top.sv
`timescale 1ns/1ns

module lab_top
# (
    parameter bit_cycles = 217
)
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        tick,
    input  logic [2:0]                  key,
    input  logic [lab_pkg::w_sw  - 1:0] sw,
    output logic [lab_pkg::w_led - 1:0] led,
    output logic                        uart_tx
);

    lab_pkg::key_evt_t    key_evt;
    lab_pkg::step_shift_t sw_sync;
    lab_pkg::lab_ctrl_t   ctrl;
    lab_pkg::count_t      count;
    logic                 count_new;

    ////////////////////////////////////////
    // key front end and settings
    ////////////////////////////////////////

    key_sync i_key_sync
    (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .key     ( key     ),
        .sw      ( sw      ),
        .key_evt ( key_evt ),
        .sw_sync ( sw_sync )
    );

    lab_ctrl_regs i_lab_ctrl_regs
    (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .key_evt ( key_evt ),
        .sw_sync ( sw_sync ),
        .ctrl    ( ctrl    )
    );

    ////////////////////////////////////////
    // counter and serial output
    ////////////////////////////////////////

    lab_counter i_lab_counter
    (
        .clk       ( clk           ),
        .rst       ( rst           ),
        .tick      ( tick          ),
        .clear     ( key_evt.clear ),  // straight from the key front end.
        .ctrl      ( ctrl          ),
        .count     ( count         ),
        .count_new ( count_new     )
    );

    uart_byte_tx # (.bit_cycles (bit_cycles)) i_uart_byte_tx
    (
        .clk  ( clk       ),
        .rst  ( rst       ),
        .data ( count     ),
        .load ( count_new ),
        .tx   ( uart_tx   )
    );

    assign led = count [lab_pkg::w_led - 1:0];  // low nibble.

endmodule

// File: verilog/board_specific_top.sv
`timescale 1ns/1ns

module board_specific_top
# (
    parameter clk_mhz = 25,
              slow_hz = 4,
              baud    = 115200
)
(
    input  logic                        CLK,
    input  logic [lab_pkg::w_key - 1:0] KEY,
    input  logic [lab_pkg::w_sw  - 1:0] SW,
    output logic [lab_pkg::w_led - 1:0] LED,
    output logic                        UART_TX
);

    localparam period_cycles = clk_mhz * 1000000 / slow_hz;
    localparam bit_cycles    = clk_mhz * 1000000 / baud;

    logic clk;
    logic rst;
    logic tick;

    assign clk = CLK;
    assign rst = KEY [lab_pkg::w_key - 1];      // last key is the reset.

    ////////////////////////////////////////
    // slow tick strobe on the main clock
    ////////////////////////////////////////

    slow_clk_gen # (.period_cycles (period_cycles)) i_slow_clk_gen
    (
        .clk  ( clk  ),
        .rst  ( rst  ),
        .tick ( tick )
    );

    ////////////////////////////////////////
    // lab
    ////////////////////////////////////////

    lab_top # (.bit_cycles (bit_cycles)) i_lab_top
    (
        .clk     ( clk                          ),
        .rst     ( rst                          ),
        .tick    ( tick                         ),
        .key     ( KEY [lab_pkg::w_key - 2:0]   ),
        .sw      ( SW                           ),
        .led     ( LED                          ),
        .uart_tx ( UART_TX                      )
    );

endmodule

// File: tb/lab_counter_props.sv
`timescale 1ns/1ns

module lab_counter_props
(
    input logic            clk,
    input logic            rst,
    input logic            tick,
    input logic            clear,
    input lab_pkg::count_t count,
    input logic            count_new
);

    reset_state: assert property (@ (posedge clk) rst |=> (count == '0 && !count_new))
        else $error("count or count_new not cleared after reset");

    // an unknown start value makes the compare vacuous.
    count_cause: assert property (@ (posedge clk)
                                  (count != $past(count)) |-> $past(tick || clear || rst))
        else $error("count changed without tick, clear or reset");

    single_strobe: assert property (@ (posedge clk) count_new |=> !count_new)
        else $error("count_new high for two cycles");

endmodule

bind lab_counter lab_counter_props props0
(
    .clk       ( clk       ),
    .rst       ( rst       ),
    .tick      ( tick      ),
    .clear     ( clear     ),
    .count     ( count     ),
    .count_new ( count_new )
);

// File: tb/tb_board_top.sv
`timescale 1ns/1ns

module tb_board_top;

    localparam clk_mhz       = 1;
    localparam slow_hz       = 1000;
    localparam baud          = 100000;
    localparam clk_period    = 8;
    localparam period_cycles = clk_mhz * 1000000 / slow_hz;  // cycles between ticks.
    localparam bit_cycles    = clk_mhz * 1000000 / baud;     // cycles per serial bit.
    localparam tick_budget   = 70;                           // tick periods of all tests.

    logic                        clk;
    logic [lab_pkg::w_key - 1:0] key;
    logic [lab_pkg::w_sw  - 1:0] sw;
    logic [lab_pkg::w_led - 1:0] led;
    logic                        uart_tx;

    logic [31:0]                 rng_state;
    lab_pkg::count_t             exp_count;                  // reference model state.
    logic                        exp_down;
    logic                        exp_run;
    lab_pkg::step_shift_t        exp_shift;

    board_specific_top # (.clk_mhz (clk_mhz), .slow_hz (slow_hz), .baud (baud)) dut0
    (
        .CLK     ( clk     ),
        .KEY     ( key     ),
        .SW      ( sw      ),
        .LED     ( led     ),
        .UART_TX ( uart_tx )
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        #(2 * tick_budget * period_cycles * clk_period);
        $display("timeout: the tests did not finish within %0d tick periods",
                 2 * tick_budget);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic int unsigned next_random(input int unsigned bound);
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return (rng_state >> 16) % bound;                    // upper bits are less regular.
    endfunction

    // switch code to step size.
    function automatic lab_pkg::count_t step_size(input lab_pkg::step_shift_t shift);
        case (shift)
        2'd0:    return 8'd1;
        2'd1:    return 8'd2;
        2'd2:    return 8'd4;
        default: return 8'd8;
        endcase
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected)
        begin
            $display("ERR at %0t ns: %s, got %0d, expected %0d", $time, msg, actual, expected);
            $display("Some tests failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic press_key(input int idx);
        @ (posedge clk);
        key[idx] <= 1'b1;
        repeat (4) @ (posedge clk);
        key[idx] <= 1'b0;
        repeat (6) @ (posedge clk);                          // event and ctrl settle.
    endtask

    task automatic set_switches(input lab_pkg::step_shift_t value);
        @ (posedge clk);
        sw        <= value;
        exp_shift = value;
        repeat (4) @ (posedge clk);
    endtask

    task automatic receive_byte(output lab_pkg::count_t data);
        int i;
        data = '0;
        @ (negedge clk);
        while (uart_tx !== 1'b0)
            @ (negedge clk);
        repeat (bit_cycles / 2) @ (negedge clk);             // middle of the start bit.
        check(32'(uart_tx), 32'd0, "uart start bit");
        for (i = 0; i < 8; i++)
        begin
            repeat (bit_cycles) @ (negedge clk);
            data[i] = uart_tx;                               // lsb first.
        end
        repeat (bit_cycles) @ (negedge clk);
        check(32'(uart_tx), 32'd1, "uart stop bit");
    endtask

    // one tick of the model, then the frame it predicts.
    task automatic take_frame(input string msg);
        lab_pkg::count_t got;
        if (exp_run)
            exp_count = exp_down ? exp_count - step_size(exp_shift)
                                 : exp_count + step_size(exp_shift);
        receive_byte(got);
        check(32'(got), 32'(exp_count), msg);
        check(32'(led), 32'(exp_count[3:0]), {msg, ", led nibble"});
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic test_reset_state();
        @ (negedge clk);
        check(32'(led), 32'd0, "led after reset");
        repeat (period_cycles - 4)
        begin
            @ (negedge clk);
            check(32'(uart_tx), 32'd1, "uart idle before the first tick");
        end
    endtask

    task automatic test_count_up();
        int unsigned n;
        n = 3 + next_random(4);
        repeat (n) take_frame("count up by one");
    endtask

    task automatic test_step_size();
        int unsigned n;
        logic        wrapped;
        repeat (4)
        begin
            set_switches(lab_pkg::step_shift_t'(next_random(4)));
            n = 1 + next_random(3);
            repeat (n) take_frame("random step size");
        end
        set_switches(2'd3);
        wrapped = 1'b0;
        while (!wrapped)
        begin
            wrapped = (exp_count > 8'd247);                  // next step of 8 passes 255.
            take_frame("step of 8 wraps past 255");
        end
    endtask

    task automatic test_direction();
        logic wrapped;
        set_switches(lab_pkg::step_shift_t'(next_random(4)));
        press_key(0);
        exp_down = ~exp_down;
        wrapped  = 1'b0;
        while (!wrapped)
        begin
            wrapped = (exp_count < step_size(exp_shift));    // next step goes below zero.
            take_frame("count down");
        end
    endtask

    task automatic test_pause();
        press_key(1);
        exp_run = 1'b0;
        repeat (3 * period_cycles)
        begin
            @ (negedge clk);
            check(32'(uart_tx), 32'd1, "no frame while paused");
            check(32'(led), 32'(exp_count[3:0]), "led holds while paused");
        end
        press_key(1);
        exp_run = 1'b1;
        take_frame("resume after pause");
    endtask

    task automatic test_clear();
        press_key(2);
        exp_count = '0;
        @ (negedge clk);
        check(32'(led), 32'd0, "led after clear");
        take_frame("first step down after clear");          // 256 minus the step.
        press_key(0);
        exp_down = ~exp_down;
        press_key(2);
        exp_count = '0;
        @ (negedge clk);
        check(32'(led), 32'd0, "led after second clear");
        take_frame("first step up after clear");
    endtask

    initial
    begin
        rng_state = 32'h774add4f;
        exp_count = '0;
        exp_down  = 1'b0;
        exp_run   = 1'b1;
        exp_shift = '0;
        key      <= 4'b1000;                                 // reset key held down.
        sw       <= '0;
        repeat (16) @ (posedge clk);
        key[lab_pkg::w_key - 1] <= 1'b0;
        test_reset_state();
        test_count_up();
        test_step_size();
        test_direction();
        test_pause();
        test_clear();
        $display("All tests passed");
        $finish;
    end

endmodule

// File: tb.f
verilog/lab_pkg.sv
verilog/slow_clk_gen.sv
verilog/key_sync.sv
verilog/lab_ctrl_regs.sv
verilog/lab_counter.sv
verilog/uart_byte_tx.sv
verilog/lab_top.sv
verilog/board_specific_top.sv
tb/lab_counter_props.sv
tb/tb_board_top.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_board_top
FILE_LIST  := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
